/* src/rv_pkg.sv */
package rv_pkg;

    // datapath and register address widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // instruction field widths
    localparam int OPC_W = 7;
    localparam int F3_W  = 3;
    localparam int F7_W  = 7;

    // major opcodes
    localparam logic [OPC_W-1:0] OPC_TYPE_I = 7'b001_0011;
    localparam logic [OPC_W-1:0] OPC_TYPE_R = 7'b011_0011;
    localparam logic [OPC_W-1:0] OPC_TYPE_B = 7'b110_0011;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b110_1111;
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b011_0111;

    // funct3 codes
    localparam logic [F3_W-1:0] F3_ADDI    = 3'b000;
    localparam logic [F3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [F3_W-1:0] F3_BEQ     = 3'b000;
    localparam logic [F3_W-1:0] F3_BNE     = 3'b001;

    // funct7 codes
    localparam logic [F7_W-1:0] F7_ADD = 7'b000_0000;
    localparam logic [F7_W-1:0] F7_SUB = 7'b010_0000;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] INST_NOP = 32'h0000_0013;

endpackage

/* src/fetch.sv */
module fetch #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    jump_en_i,
    input  logic [rv_pkg::XLEN-1:0] jump_addr_i,
    input  logic [rv_pkg::XLEN-1:0] inst_i,
    output logic [rv_pkg::XLEN-1:0] inst_addr_o,
    output logic [rv_pkg::XLEN-1:0] inst_o,
    output logic [rv_pkg::XLEN-1:0] inst_pc_o
);

    import rv_pkg::*;

    logic [XLEN-1:0] pc;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc <= RESET_PC;
        end else if (jump_en_i) begin
            pc <= jump_addr_i;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    assign inst_addr_o = pc;

    // fetch/decode register, killed on redirect
    always_ff @(posedge clk) begin
        if (rst_i || jump_en_i) begin
            inst_o    <= INST_NOP;
            inst_pc_o <= '0;
        end else begin
            inst_o    <= inst_i;
            inst_pc_o <= pc;
        end
    end

endmodule

/* src/decode.sv */
module decode (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      flush_i,
    input  logic [rv_pkg::XLEN-1:0]   inst_i,
    input  logic [rv_pkg::XLEN-1:0]   inst_addr_i,
    output logic [rv_pkg::REG_AW-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_AW-1:0] rs2_addr_o,
    input  logic [rv_pkg::XLEN-1:0]   rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]   rs2_data_i,
    output logic [rv_pkg::XLEN-1:0]   inst_o,
    output logic [rv_pkg::XLEN-1:0]   inst_addr_o,
    output logic [rv_pkg::XLEN-1:0]   op1_o,
    output logic [rv_pkg::XLEN-1:0]   op2_o,
    output logic [rv_pkg::REG_AW-1:0] rd_addr_o
);

    import rv_pkg::*;

    logic [OPC_W-1:0]  opcode;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_j;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;

    assign opcode     = inst_i[6:0];
    assign rd         = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    // operand select by instruction type
    always_comb begin
        op1 = '0;
        op2 = '0;
        case (opcode)
            OPC_TYPE_I: begin
                op1 = rs1_data_i;
                op2 = imm_i;
            end
            OPC_TYPE_R, OPC_TYPE_B: begin
                op1 = rs1_data_i;
                op2 = rs2_data_i;
            end
            OPC_JAL: begin
                op1 = imm_j; // jump offset
            end
            OPC_LUI: begin
                op1 = imm_u;
            end
            default: begin
                op1 = '0;
                op2 = '0;
            end
        endcase
    end

    // decode/execute register
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            inst_o      <= INST_NOP;
            inst_addr_o <= '0;
            op1_o       <= '0;
            op2_o       <= '0;
            rd_addr_o   <= '0;
        end else begin
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
            op1_o       <= op1;
            op2_o       <= op2;
            rd_addr_o   <= rd;
        end
    end

endmodule

/* src/execute.sv */
module execute (
    input  logic [rv_pkg::XLEN-1:0]   inst_i,
    input  logic [rv_pkg::XLEN-1:0]   inst_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   op1_i,
    input  logic [rv_pkg::XLEN-1:0]   op2_i,
    input  logic [rv_pkg::REG_AW-1:0] rd_addr_i,
    output logic                      wb_en_o,
    output logic [rv_pkg::REG_AW-1:0] wb_addr_o,
    output logic [rv_pkg::XLEN-1:0]   wb_data_o,
    output logic                      jump_en_o,
    output logic [rv_pkg::XLEN-1:0]   jump_addr_o
);

    import rv_pkg::*;

    logic [OPC_W-1:0] opcode;
    logic [F3_W-1:0]  funct3;
    logic [F7_W-1:0]  funct7;
    logic [XLEN-1:0]  imm_b;
    logic [XLEN-1:0]  br_target;
    logic             ops_equal;
    logic             wr_req;
    logic [XLEN-1:0]  wr_data;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_b     = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign br_target = inst_addr_i + imm_b;
    assign ops_equal = (op1_i == op2_i);

    always_comb begin
        wr_req      = 1'b0;
        wr_data     = '0;
        jump_en_o   = 1'b0;
        jump_addr_o = '0;
        case (opcode)
            OPC_TYPE_I: begin
                if (funct3 == F3_ADDI) begin
                    wr_req  = 1'b1;
                    wr_data = op1_i + op2_i;
                end
            end
            OPC_TYPE_R: begin
                if (funct3 == F3_ADD_SUB) begin
                    if (funct7 == F7_ADD) begin
                        wr_req  = 1'b1;
                        wr_data = op1_i + op2_i;
                    end else if (funct7 == F7_SUB) begin
                        wr_req  = 1'b1;
                        wr_data = op1_i - op2_i;
                    end
                end
            end
            OPC_TYPE_B: begin
                if ((funct3 == F3_BEQ && ops_equal) || (funct3 == F3_BNE && !ops_equal)) begin
                    jump_en_o   = 1'b1;
                    jump_addr_o = br_target;
                end
            end
            OPC_JAL: begin
                wr_req      = 1'b1;
                wr_data     = inst_addr_i + 32'd4; // link
                jump_en_o   = 1'b1;
                jump_addr_o = inst_addr_i + op1_i;
            end
            OPC_LUI: begin
                wr_req  = 1'b1;
                wr_data = op1_i;
            end
            default: begin
                wr_req = 1'b0;
            end
        endcase
    end

    // nop bubbles target x0 and never show as writes
    assign wb_en_o   = wr_req && (rd_addr_i != '0);
    assign wb_addr_o = wb_en_o ? rd_addr_i : '0;
    assign wb_data_o = wb_en_o ? wr_data : '0;

endmodule

/* src/regfile.sv */
module regfile (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      we_i,
    input  logic [rv_pkg::REG_AW-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]   wdata_i,
    input  logic [rv_pkg::REG_AW-1:0] raddr1_i,
    input  logic [rv_pkg::REG_AW-1:0] raddr2_i,
    output logic [rv_pkg::XLEN-1:0]   rdata1_o,
    output logic [rv_pkg::XLEN-1:0]   rdata2_o
);

    import rv_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];
    logic            wr_ok;

    assign wr_ok = we_i && (waddr_i != '0); // x0 stays zero

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle bypass of the write port
    always_comb begin
        if (raddr1_i == '0)                  rdata1_o = '0;
        else if (wr_ok && raddr1_i == waddr_i) rdata1_o = wdata_i;
        else                                 rdata1_o = regs[raddr1_i];
        if (raddr2_i == '0)                  rdata2_o = '0;
        else if (wr_ok && raddr2_i == waddr_i) rdata2_o = wdata_i;
        else                                 rdata2_o = regs[raddr2_i];
    end

endmodule

/* src/core_top.sv */
module core_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      rst_i,
    output logic [rv_pkg::XLEN-1:0]   inst_addr_o,
    input  logic [rv_pkg::XLEN-1:0]   inst_i,
    output logic                      wb_en_o,
    output logic [rv_pkg::REG_AW-1:0] wb_addr_o,
    output logic [rv_pkg::XLEN-1:0]   wb_data_o,
    output logic                      jump_en_o,
    output logic [rv_pkg::XLEN-1:0]   jump_addr_o
);

    import rv_pkg::*;

    // fetch to decode
    logic [XLEN-1:0]   if_inst;
    logic [XLEN-1:0]   if_inst_pc;

    // decode to regfile
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;

    // decode to execute
    logic [XLEN-1:0]   id_inst;
    logic [XLEN-1:0]   id_inst_addr;
    logic [XLEN-1:0]   id_op1;
    logic [XLEN-1:0]   id_op2;
    logic [REG_AW-1:0] id_rd_addr;

    fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_i       (rst_i),
        .jump_en_i   (jump_en_o),
        .jump_addr_i (jump_addr_o),
        .inst_i      (inst_i),
        .inst_addr_o (inst_addr_o),
        .inst_o      (if_inst),
        .inst_pc_o   (if_inst_pc)
    );

    decode u_decode (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (jump_en_o), // kill the older of the two
        .inst_i      (if_inst),
        .inst_addr_i (if_inst_pc),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .inst_o      (id_inst),
        .inst_addr_o (id_inst_addr),
        .op1_o       (id_op1),
        .op2_o       (id_op2),
        .rd_addr_o   (id_rd_addr)
    );

    execute u_execute (
        .inst_i      (id_inst),
        .inst_addr_i (id_inst_addr),
        .op1_i       (id_op1),
        .op2_i       (id_op2),
        .rd_addr_i   (id_rd_addr),
        .wb_en_o     (wb_en_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o),
        .jump_en_o   (jump_en_o),
        .jump_addr_o (jump_addr_o)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (wb_en_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

endmodule

/* tb/core_tb.sv */
module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int              WORDS    = 64;
    localparam int              PERIOD   = 100;
    localparam int              LIMIT    = (WORDS + 8) * 2; // cycles, two per instruction
    localparam logic [XLEN-1:0] RESET_PC = '0;

    logic              clk;
    logic              rst_i;
    logic [XLEN-1:0]   inst_addr;
    logic [XLEN-1:0]   inst;
    logic              wb_en;
    logic [REG_AW-1:0] wb_addr;
    logic [XLEN-1:0]   wb_data;
    logic              jump_en;
    logic [XLEN-1:0]   jump_addr;

    logic [XLEN-1:0]   prog [WORDS];
    logic [REG_AW-1:0] exp_waddr [$];
    logic [XLEN-1:0]   exp_wdata [$];
    logic [XLEN-1:0]   exp_jump [$];
    integer            seed;
    int                bad_values;
    int                bad_events;

    core_top #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk         (clk),
        .rst_i       (rst_i),
        .inst_addr_o (inst_addr),
        .inst_i      (inst),
        .wb_en_o     (wb_en),
        .wb_addr_o   (wb_addr),
        .wb_data_o   (wb_data),
        .jump_en_o   (jump_en),
        .jump_addr_o (jump_addr)
    );

    // instruction memory, nop past the end
    assign inst = (inst_addr < WORDS * 4) ? prog[inst_addr >> 2] : INST_NOP;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic fill_program();
        logic [XLEN-1:0]   r;
        logic [12:0]       off;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        for (int i = 0; i < WORDS; i++) begin
            r   = $random(seed);
            rd  = {2'b00, r[2:0]}; // x0..x7 so hazards are common
            rs1 = {2'b00, r[5:3]};
            rs2 = {2'b00, r[8:6]};
            off = 13'd8 + {8'b0, r[11:9], 2'b00}; // forward only
            case ($unsigned($random(seed)) % 9)
                0: prog[i] = {r[31:20], rs1, F3_ADDI, rd, OPC_TYPE_I};
                1: prog[i] = {F7_ADD, rs2, rs1, F3_ADD_SUB, rd, OPC_TYPE_R};
                2: prog[i] = {F7_SUB, rs2, rs1, F3_ADD_SUB, rd, OPC_TYPE_R};
                3: prog[i] = {off[12], off[10:5], rs2, rs1, F3_BEQ, off[4:1], off[11], OPC_TYPE_B};
                4: prog[i] = {off[12], off[10:5], rs2, rs1, F3_BNE, off[4:1], off[11], OPC_TYPE_B};
                5: prog[i] = {1'b0, off[10:1], off[11], 8'b0, rd, OPC_JAL};
                6: prog[i] = {r[31:12], rd, OPC_LUI};
                7: prog[i] = {7'b000_0001, rs2, rs1, F3_ADD_SUB, rd, OPC_TYPE_R}; // mul
                default: prog[i] = {r[31:12], rd, 7'b000_0011}; // load
            endcase
        end
    endtask

    // instruction-set model, one instruction per step
    task automatic run_model();
        logic [XLEN-1:0] x [2**REG_AW];
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] next;
        logic            wr;
        for (int i = 0; i < 2**REG_AW; i++) begin
            x[i] = '0;
        end
        pc = RESET_PC;
        while (pc < WORDS * 4) begin
            w    = prog[pc >> 2];
            a    = x[w[19:15]];
            b    = x[w[24:20]];
            wr   = 1'b0;
            res  = '0;
            next = pc + 4;
            case (w[6:0])
                OPC_TYPE_I: begin
                    wr  = (w[14:12] == F3_ADDI);
                    res = a + {{20{w[31]}}, w[31:20]};
                end
                OPC_TYPE_R: begin
                    wr  = (w[14:12] == F3_ADD_SUB) && (w[31:25] == F7_ADD || w[31:25] == F7_SUB);
                    res = (w[31:25] == F7_SUB) ? a - b : a + b;
                end
                OPC_TYPE_B: begin
                    if ((w[14:12] == F3_BEQ && a == b) || (w[14:12] == F3_BNE && a != b)) begin
                        next = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                        exp_jump.push_back(next);
                    end
                end
                OPC_JAL: begin
                    wr   = 1'b1;
                    res  = pc + 4; // link
                    next = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                    exp_jump.push_back(next);
                end
                OPC_LUI: begin
                    wr  = 1'b1;
                    res = {w[31:12], 12'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 0) begin
                x[w[11:7]] = res;
                exp_waddr.push_back(w[11:7]);
                exp_wdata.push_back(res);
            end
            pc = next;
        end
    endtask

    task automatic check_write(input logic [REG_AW-1:0] addr, input logic [XLEN-1:0] data);
        if (exp_waddr.size() == 0) begin
            $display("unexpected register write of %h to x%0d at %0t", data, addr, $time);
            bad_events++;
        end else begin
            if (addr !== exp_waddr[0]) begin
                $display("Error: wb_addr_o got %h expected %h", addr, exp_waddr[0]);
                bad_values++;
            end
            if (data !== exp_wdata[0]) begin
                $display("Error: wb_data_o got %h expected %h", data, exp_wdata[0]);
                bad_values++;
            end
            void'(exp_waddr.pop_front());
            void'(exp_wdata.pop_front());
        end
    endtask

    task automatic check_jump(input logic [XLEN-1:0] addr);
        if (exp_jump.size() == 0) begin
            $display("unexpected jump to %h at %0t", addr, $time);
            bad_events++;
        end else begin
            if (addr !== exp_jump[0]) begin
                $display("Error: jump_addr_o got %h expected %h", addr, exp_jump[0]);
                bad_values++;
            end
            void'(exp_jump.pop_front());
        end
    endtask

    task automatic check_pc(input logic [XLEN-1:0] addr);
        if (addr !== RESET_PC) begin
            $display("Error: inst_addr_o got %h expected %h", addr, RESET_PC);
            bad_values++;
        end
    endtask

    task automatic check_quiet(input logic wen, input logic jen);
        if (wen !== 1'b0 || jen !== 1'b0) begin
            $display("Error: wb_en_o/jump_en_o got %h/%h expected 0/0", wen, jen);
            bad_values++;
        end
    endtask

    initial begin
        int beyond;
        int cycle;
        seed       = 32'hf7b8_3acd;
        bad_values = 0;
        bad_events = 0;
        beyond     = 0;
        cycle      = 0;
        rst_i      = 1'b1;
        fill_program();
        run_model();
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        // pipeline drains three cycles after the pc leaves the program
        while (beyond < 3) begin
            @(negedge clk);
            if (cycle == 0)
                check_pc(inst_addr);
            if (cycle < 2)
                check_quiet(wb_en, jump_en); // first instruction not yet in execute
            if (wb_en)
                check_write(wb_addr, wb_data);
            if (jump_en)
                check_jump(jump_addr);
            if (inst_addr >= WORDS * 4)
                beyond++;
            cycle++;
        end
        if (exp_waddr.size() + exp_jump.size() != 0) begin
            $display("%0d register writes and %0d jumps never appeared",
                     exp_waddr.size(), exp_jump.size());
            bad_events++;
        end
        $display("errors: %0d wrong values, %0d missing or unexpected events",
                 bad_values, bad_events);
        if (bad_values + bad_events == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(LIMIT * PERIOD);
        $display("watchdog expired after %0d cycles, the program never finished", LIMIT);
        $display("errors: %0d wrong values, %0d missing or unexpected events",
                 bad_values, bad_events);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* sim.f */
src/rv_pkg.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/regfile.sv
src/core_top.sv
tb/core_tb.sv

/* Bender.yml */
package:
  name: rv32i_core_slice

sources:
  - src/rv_pkg.sv
  - src/fetch.sv
  - src/decode.sv
  - src/execute.sv
  - src/regfile.sv
  - src/core_top.sv
  - target: test
    files:
      - tb/core_tb.sv
